//--- tcb_lsu_pkg.sv
/*
 * load/store path package
 * bus widths, memory size, response delays, lane mask and opcodes
 */
`default_nettype none

package tcb_lsu_pkg;

    //////////////////////////////
    // bus geometry
    //////////////////////////////

    // byte address width
    localparam int unsigned ADR_W = 10;
    // data bus width
    localparam int unsigned DAT_W = 32;
    // number of byte lanes
    localparam int unsigned BYT_W = DAT_W / 8;
    // logarithmic size field, 0/1/2 for 1/2/4 bytes
    localparam int unsigned SIZ_W = 2;
    // address bits selecting a lane inside a word
    localparam int unsigned OFF_W = $clog2(BYT_W);

    //////////////////////////////
    // memory and delays
    //////////////////////////////

    // memory capacity in bytes, addresses at or above are out of range
    localparam int unsigned MEM_BYTES = 256;
    localparam int unsigned MEM_WORDS = MEM_BYTES / BYT_W;
    localparam int unsigned MEM_IDX_W = $clog2(MEM_WORDS);

    // memory answers one cycle after its transfer
    localparam int unsigned MEM_DLY = 1;
    // manager sees one more cycle through the request slice
    localparam int unsigned BUS_DLY = MEM_DLY + 1;

    // load/store opcodes
    typedef enum logic [2:0] {
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW
    } op_t;

    // byte lanes touched by an access of 2**siz bytes at lane offset off
    function automatic logic [BYT_W-1:0] lane_msk(
        input logic [OFF_W-1:0] off,
        input logic [SIZ_W-1:0] siz
    );
        logic [BYT_W-1:0] base;
        // lanes from 0 up to the access size
        base = BYT_W'((1 << (1 << siz)) - 1);
        // then moved up to the addressed offset
        return BYT_W'(base << off);
    endfunction

endpackage : tcb_lsu_pkg

`default_nettype wire

//--- tcb_lsu_manager.sv
/*
 * load/store unit, bus manager side
 * turns opcode/address/data commands into sized bus requests
 * and aligns and extends the read data of each response
 */
`default_nettype none

module tcb_lsu_manager (
    input  wire logic                           sub,
    input  wire logic                           rst_n,
    // command port
    input  wire logic                           cmd_vld,
    input  wire tcb_lsu_pkg::op_t               cmd_op,
    input  wire logic [tcb_lsu_pkg::ADR_W-1:0]  cmd_adr,
    input  wire logic [tcb_lsu_pkg::DAT_W-1:0]  cmd_wdt,
    output logic                                cmd_rdy,
    // response port
    output logic                                rsp_vld,
    output logic      [tcb_lsu_pkg::DAT_W-1:0]  rsp_rdt,
    output logic                                rsp_err,
    // bus request
    output logic                                bus_vld,
    output logic                                bus_wen,
    output logic      [tcb_lsu_pkg::ADR_W-1:0]  bus_adr,
    output logic      [tcb_lsu_pkg::SIZ_W-1:0]  bus_siz,
    output logic      [tcb_lsu_pkg::DAT_W-1:0]  bus_wdt,
    // bus response
    input  wire logic                           bus_rdy,
    input  wire logic [tcb_lsu_pkg::DAT_W-1:0]  bus_rdt,
    input  wire logic                           bus_err
);

    import tcb_lsu_pkg::*;

    // transfer on the upstream segment
    logic             trn;

    // record of accepted commands, index is the stage
    logic [BUS_DLY-1:0] rec_vld;
    op_t              rec_op  [BUS_DLY];
    logic [OFF_W-1:0] rec_off [BUS_DLY];

    // read data moved down to lane 0
    logic [DAT_W-1:0] rdt_sft;

    //////////////////////////////
    // request
    //////////////////////////////

    // command handshake is the bus handshake
    assign bus_vld = cmd_vld;
    assign cmd_rdy = bus_rdy;
    assign bus_adr = cmd_adr;
    assign trn     = bus_vld & bus_rdy;

    // opcode decode into write enable and log2 size
    always_comb begin
        case (cmd_op)
            OP_LB, OP_LBU: begin
                bus_wen = 1'b0;
                bus_siz = SIZ_W'(0);
            end
            OP_LH, OP_LHU: begin
                bus_wen = 1'b0;
                bus_siz = SIZ_W'(1);
            end
            OP_SB: begin
                bus_wen = 1'b1;
                bus_siz = SIZ_W'(0);
            end
            OP_SH: begin
                bus_wen = 1'b1;
                bus_siz = SIZ_W'(1);
            end
            OP_SW: begin
                bus_wen = 1'b1;
                bus_siz = SIZ_W'(2);
            end
            default: begin
                // OP_LW
                bus_wen = 1'b0;
                bus_siz = SIZ_W'(2);
            end
        endcase
    end

    // replicate narrow store data so every offset sees it on its lane
    always_comb begin
        case (cmd_op)
            OP_SB:   bus_wdt = {BYT_W{cmd_wdt[7:0]}};
            OP_SH:   bus_wdt = {(BYT_W/2){cmd_wdt[15:0]}};
            default: bus_wdt = cmd_wdt;
        endcase
    end

    //////////////////////////////
    // response
    //////////////////////////////

    // valid bits of the record
    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            rec_vld <= '0;
        end else begin
            rec_vld <= {rec_vld[BUS_DLY-2:0], trn};
        end
    end

    // opcode and lane offset follow the valid bits
    always_ff @(posedge sub) begin
        rec_op[0]  <= cmd_op;
        rec_off[0] <= cmd_adr[OFF_W-1:0];
        for (int i = 1; i < BUS_DLY; i++) begin
            rec_op[i]  <= rec_op[i-1];
            rec_off[i] <= rec_off[i-1];
        end
    end

    // addressed bytes down to lane 0
    assign rdt_sft = bus_rdt >> {rec_off[BUS_DLY-1], 3'b000};

    // sign or zero extension per opcode
    always_comb begin
        case (rec_op[BUS_DLY-1])
            OP_LB:   rsp_rdt = {{(DAT_W-8){rdt_sft[7]}}, rdt_sft[7:0]};
            OP_LBU:  rsp_rdt = {{(DAT_W-8){1'b0}}, rdt_sft[7:0]};
            OP_LH:   rsp_rdt = {{(DAT_W-16){rdt_sft[15]}}, rdt_sft[15:0]};
            OP_LHU:  rsp_rdt = {{(DAT_W-16){1'b0}}, rdt_sft[15:0]};
            OP_LW:   rsp_rdt = rdt_sft;
            // stores return nothing
            default: rsp_rdt = '0;
        endcase
    end

    assign rsp_vld = rec_vld[BUS_DLY-1];
    assign rsp_err = bus_err;

endmodule : tcb_lsu_manager

`default_nettype wire

//--- tcb_register_request.sv
/*
 * request path register slice
 * registers the request fields, response passes straight through
 */
`default_nettype none

module tcb_register_request (
    input  wire logic                           sub,
    input  wire logic                           rst_n,
    // upstream, manager connects here
    input  wire logic                           up_vld,
    input  wire logic                           up_wen,
    input  wire logic [tcb_lsu_pkg::ADR_W-1:0]  up_adr,
    input  wire logic [tcb_lsu_pkg::SIZ_W-1:0]  up_siz,
    input  wire logic [tcb_lsu_pkg::DAT_W-1:0]  up_wdt,
    output logic                                up_rdy,
    output logic      [tcb_lsu_pkg::DAT_W-1:0]  up_rdt,
    output logic                                up_err,
    // downstream, subordinate connects here
    output logic                                dn_vld,
    output logic                                dn_wen,
    output logic      [tcb_lsu_pkg::ADR_W-1:0]  dn_adr,
    output logic      [tcb_lsu_pkg::SIZ_W-1:0]  dn_siz,
    output logic      [tcb_lsu_pkg::DAT_W-1:0]  dn_wdt,
    input  wire logic                           dn_rdy,
    input  wire logic [tcb_lsu_pkg::DAT_W-1:0]  dn_rdt,
    input  wire logic                           dn_err
);

    import tcb_lsu_pkg::*;

    // upstream transfer
    logic             up_trn;
    // lanes covered by the incoming access
    logic [BYT_W-1:0] up_msk;

    // an empty slice always accepts, no bubble
    assign up_rdy = dn_rdy | ~dn_vld;
    assign up_trn = up_vld & up_rdy;
    assign up_msk = lane_msk(up_adr[OFF_W-1:0], up_siz);

    //////////////////////////////
    // handshake
    //////////////////////////////

    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            dn_vld <= 1'b0;
        end else if (up_rdy) begin
            dn_vld <= up_vld;
        end
    end

    //////////////////////////////
    // request fields
    //////////////////////////////

    // item is held while downstream stalls
    always_ff @(posedge sub) begin
        if (up_trn) begin
            dn_wen <= up_wen;
            dn_adr <= up_adr;
            dn_siz <= up_siz;
        end
    end

    // write data lanes only toggle when a write uses them
    for (genvar i = 0; i < BYT_W; i++) begin : g_wdt
        always_ff @(posedge sub) begin
            if (up_trn & up_wen & up_msk[i]) begin
                dn_wdt[i*8+:8] <= up_wdt[i*8+:8];
            end
        end
    end

    // response
    assign up_rdt = dn_rdt;
    assign up_err = dn_err;

endmodule : tcb_register_request

`default_nettype wire

//--- tcb_memory_sub.sv
/*
 * byte lane memory subordinate
 * fixed one cycle response, flags misaligned and out of range accesses
 */
`default_nettype none

module tcb_memory_sub (
    input  wire logic                           sub,
    input  wire logic                           rst_n,
    // holds the memory not ready
    input  wire logic                           mem_stall,
    // request
    input  wire logic                           vld,
    input  wire logic                           wen,
    input  wire logic [tcb_lsu_pkg::ADR_W-1:0]  adr,
    input  wire logic [tcb_lsu_pkg::SIZ_W-1:0]  siz,
    input  wire logic [tcb_lsu_pkg::DAT_W-1:0]  wdt,
    // response
    output logic                                rdy,
    output logic      [tcb_lsu_pkg::DAT_W-1:0]  rdt,
    output logic                                err
);

    import tcb_lsu_pkg::*;

    // storage, one word of four lanes per entry
    logic [DAT_W-1:0]     mem [MEM_WORDS];

    logic                 trn;
    logic                 out_rng;
    logic                 mis_aln;
    logic                 bad;
    logic [BYT_W-1:0]     msk;
    logic [DAT_W-1:0]     bit_msk;
    logic [MEM_IDX_W-1:0] idx;

    assign rdy = ~mem_stall;
    assign trn = vld & rdy;

    //////////////////////////////
    // access decode
    //////////////////////////////

    // beyond the last byte
    assign out_rng = adr >= ADR_W'(MEM_BYTES);
    // offset bits below the access size must be zero
    assign mis_aln = |(adr[OFF_W-1:0] & OFF_W'((1 << siz) - 1));
    assign bad     = out_rng | mis_aln;

    assign msk = lane_msk(adr[OFF_W-1:0], siz);
    assign idx = adr[OFF_W+:MEM_IDX_W];

    // expand lane mask to bits
    always_comb begin
        for (int i = 0; i < BYT_W; i++) begin
            bit_msk[i*8+:8] = {8{msk[i]}};
        end
    end

    //////////////////////////////
    // storage
    //////////////////////////////

    // good writes only, addressed lanes only
    always_ff @(posedge sub) begin
        if (trn & wen & ~bad) begin
            for (int i = 0; i < BYT_W; i++) begin
                if (msk[i]) mem[idx][i*8+:8] <= wdt[i*8+:8];
            end
        end
    end

    // read data, zero on errors and writes
    always_ff @(posedge sub) begin
        if (trn) begin
            rdt <= (wen | bad) ? '0 : (mem[idx] & bit_msk);
        end
    end

    // error flag lasts the response cycle only
    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            err <= 1'b0;
        end else begin
            err <= trn & bad;
        end
    end

endmodule : tcb_memory_sub

`default_nettype wire

//--- tcb_lsu_top.sv
/*
 * load/store path top level
 * manager, request slice and memory subordinate
 */
`default_nettype none

module tcb_lsu_top (
    input  wire logic                           sub,
    input  wire logic                           rst_n,
    // command
    input  wire logic                           cmd_vld,
    input  wire tcb_lsu_pkg::op_t               cmd_op,
    input  wire logic [tcb_lsu_pkg::ADR_W-1:0]  cmd_adr,
    input  wire logic [tcb_lsu_pkg::DAT_W-1:0]  cmd_wdt,
    output logic                                cmd_rdy,
    // response
    output logic                                rsp_vld,
    output logic      [tcb_lsu_pkg::DAT_W-1:0]  rsp_rdt,
    output logic                                rsp_err,
    // memory back-pressure
    input  wire logic                           mem_stall
);

    import tcb_lsu_pkg::*;

    // upstream segment, manager to slice
    logic             up_vld;
    logic             up_wen;
    logic [ADR_W-1:0] up_adr;
    logic [SIZ_W-1:0] up_siz;
    logic [DAT_W-1:0] up_wdt;
    logic             up_rdy;
    logic [DAT_W-1:0] up_rdt;
    logic             up_err;

    // downstream segment, slice to memory
    logic             dn_vld;
    logic             dn_wen;
    logic [ADR_W-1:0] dn_adr;
    logic [SIZ_W-1:0] dn_siz;
    logic [DAT_W-1:0] dn_wdt;
    logic             dn_rdy;
    logic [DAT_W-1:0] dn_rdt;
    logic             dn_err;

    tcb_lsu_manager u_man (
        .sub     (sub),
        .rst_n   (rst_n),
        .cmd_vld (cmd_vld),
        .cmd_op  (cmd_op),
        .cmd_adr (cmd_adr),
        .cmd_wdt (cmd_wdt),
        .cmd_rdy (cmd_rdy),
        .rsp_vld (rsp_vld),
        .rsp_rdt (rsp_rdt),
        .rsp_err (rsp_err),
        .bus_vld (up_vld),
        .bus_wen (up_wen),
        .bus_adr (up_adr),
        .bus_siz (up_siz),
        .bus_wdt (up_wdt),
        .bus_rdy (up_rdy),
        .bus_rdt (up_rdt),
        .bus_err (up_err)
    );

    // cuts the request path
    tcb_register_request u_slc (
        .sub    (sub),
        .rst_n  (rst_n),
        .up_vld (up_vld),
        .up_wen (up_wen),
        .up_adr (up_adr),
        .up_siz (up_siz),
        .up_wdt (up_wdt),
        .up_rdy (up_rdy),
        .up_rdt (up_rdt),
        .up_err (up_err),
        .dn_vld (dn_vld),
        .dn_wen (dn_wen),
        .dn_adr (dn_adr),
        .dn_siz (dn_siz),
        .dn_wdt (dn_wdt),
        .dn_rdy (dn_rdy),
        .dn_rdt (dn_rdt),
        .dn_err (dn_err)
    );

    tcb_memory_sub u_mem (
        .sub       (sub),
        .rst_n     (rst_n),
        .mem_stall (mem_stall),
        .vld       (dn_vld),
        .wen       (dn_wen),
        .adr       (dn_adr),
        .siz       (dn_siz),
        .wdt       (dn_wdt),
        .rdy       (dn_rdy),
        .rdt       (dn_rdt),
        .err       (dn_err)
    );

endmodule : tcb_lsu_top

`default_nettype wire

//--- tb_clock_gen.sv
/*
 * testbench clock and reset
 * 40 ns clock, active low reset held for the first five cycles
 */
`default_nettype none

module tb_clock_gen (
    output logic sub,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned PERIOD  = 40;
    localparam int unsigned RST_CYC = 5;

    initial begin
        sub = 1'b0;
        forever #(PERIOD / 2) sub = ~sub;
    end

    // release away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYC) @(posedge sub);
        #(PERIOD / 4);
        rst_n = 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

//--- tb_tcb_lsu_top.sv
/*
 * load/store path testbench
 * table of commands with expected responses, a command driver
 * and a response checker running side by side
 */
`default_nettype none

module tb_tcb_lsu_top;

    timeunit 1ns;
    timeprecision 100ps;

    import tcb_lsu_pkg::*;

    localparam int unsigned TBL_N   = 80;
    localparam int unsigned DRV_DLY = 5;
    localparam int unsigned RST_TMO = 20;
    localparam int unsigned RDY_TMO = 20;
    localparam int unsigned RSP_TMO = 50;

    logic             sub;
    logic             rst_n;
    logic             cmd_vld;
    op_t              cmd_op;
    logic [ADR_W-1:0] cmd_adr;
    logic [DAT_W-1:0] cmd_wdt;
    logic             cmd_rdy;
    logic             rsp_vld;
    logic [DAT_W-1:0] rsp_rdt;
    logic             rsp_err;
    logic             mem_stall;

    //////////////////////////////
    // command table
    //////////////////////////////

    op_t              tbl_op    [TBL_N];
    logic [ADR_W-1:0] tbl_adr   [TBL_N];
    logic [DAT_W-1:0] tbl_wdt   [TBL_N];
    int unsigned      tbl_stall [TBL_N];
    bit               tbl_b2b   [TBL_N];
    logic [DAT_W-1:0] tbl_rdt   [TBL_N];
    logic             tbl_err   [TBL_N];
    int               tbl_n = 0;

    // byte model of the memory for expected loads
    logic [7:0]       ref_mem   [MEM_BYTES];

    integer           seed = 30;
    // rising edges since time zero
    int               cyc = 0;
    // acceptance edge of each command still waiting for its response
    int               acc_q [$];
    int               n_rsp = 0;

    tb_clock_gen u_clk (
        .sub   (sub),
        .rst_n (rst_n)
    );

    tcb_lsu_top dut (
        .sub       (sub),
        .rst_n     (rst_n),
        .cmd_vld   (cmd_vld),
        .cmd_op    (cmd_op),
        .cmd_adr   (cmd_adr),
        .cmd_wdt   (cmd_wdt),
        .cmd_rdy   (cmd_rdy),
        .rsp_vld   (rsp_vld),
        .rsp_rdt   (rsp_rdt),
        .rsp_err   (rsp_err),
        .mem_stall (mem_stall)
    );

    always @(posedge sub) cyc <= cyc + 1;

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    function automatic logic [DAT_W-1:0] rand_word();
        rand_word = $random(seed);
    endfunction

    // expected response from access size, natural alignment, range and
    // little endian lanes, with extension per opcode
    task automatic add_entry(input op_t op, input int unsigned adr,
                             input logic [DAT_W-1:0] wdt,
                             input int unsigned stall, input bit b2b);
        int unsigned      n;
        bit               wen;
        bit               bad;
        logic [DAT_W-1:0] v;
        case (op)
            OP_LB, OP_LBU, OP_SB: n = 1;
            OP_LH, OP_LHU, OP_SH: n = 2;
            default:              n = 4;
        endcase
        wen = (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
        bad = (adr >= MEM_BYTES) || (adr % n != 0);
        v   = '0;
        if (!bad) begin
            for (int j = 0; j < n; j++) begin
                if (wen) ref_mem[adr+j] = wdt[j*8+:8];
                else     v[j*8+:8] = ref_mem[adr+j];
            end
        end
        // upper bytes are already zero for unsigned loads
        if (op == OP_LB) v = {{(DAT_W-8){v[7]}}, v[7:0]};
        if (op == OP_LH) v = {{(DAT_W-16){v[15]}}, v[15:0]};
        tbl_op[tbl_n]    = op;
        tbl_adr[tbl_n]   = ADR_W'(adr);
        tbl_wdt[tbl_n]   = wdt;
        tbl_stall[tbl_n] = stall;
        tbl_b2b[tbl_n]   = b2b;
        tbl_rdt[tbl_n]   = v;
        tbl_err[tbl_n]   = bad;
        tbl_n++;
    endtask

    task automatic build_table();
        logic [DAT_W-1:0] w;
        op_t              op;
        int unsigned      stl;
        // word store and load back
        add_entry(OP_SW, 'h010, rand_word(), 0, 0);
        add_entry(OP_LW, 'h010, rand_word(), 0, 0);
        // byte lanes with the sign bit set on even offsets
        add_entry(OP_SW, 'h020, rand_word(), 0, 0);
        for (int off = 0; off < 4; off++) begin
            w    = rand_word();
            w[7] = ~off[0];
            add_entry(OP_SB, 'h020 + off, w, 0, 0);
            add_entry(OP_LB, 'h020 + off, rand_word(), 0, 1);
            add_entry(OP_LBU, 'h020 + off, rand_word(), 0, 1);
            add_entry(OP_LW, 'h020, rand_word(), 0, 1);
        end
        // halfword lanes
        add_entry(OP_SW, 'h024, rand_word(), 0, 0);
        for (int off = 0; off < 4; off += 2) begin
            w     = rand_word();
            w[15] = (off == 2);
            add_entry(OP_SH, 'h024 + off, w, 0, 0);
            add_entry(OP_LH, 'h024 + off, rand_word(), 0, 1);
            add_entry(OP_LHU, 'h024 + off, rand_word(), 0, 1);
            add_entry(OP_LW, 'h024, rand_word(), 0, 1);
        end
        // misaligned and out of range accesses leave their target words alone
        add_entry(OP_SW, 'h030, rand_word(), 0, 0);
        // words that out of range addresses would hit if wrapped
        add_entry(OP_SW, 'h000, rand_word(), 0, 0);
        add_entry(OP_SW, 'h0fc, rand_word(), 0, 0);
        add_entry(OP_SH, 'h031, rand_word(), 0, 0);
        add_entry(OP_SW, 'h032, rand_word(), 0, 0);
        add_entry(OP_LH, 'h033, rand_word(), 0, 0);
        add_entry(OP_LW, 'h031, rand_word(), 0, 0);
        add_entry(OP_SB, 'h100, rand_word(), 0, 0);
        add_entry(OP_SW, 'h1fc, rand_word(), 0, 0);
        add_entry(OP_LB, 'h3ff, rand_word(), 0, 0);
        add_entry(OP_LW, 'h030, rand_word(), 0, 0);
        add_entry(OP_LW, 'h000, rand_word(), 0, 0);
        add_entry(OP_LW, 'h0fc, rand_word(), 0, 0);
        // back to back burst
        add_entry(OP_SW, 'h040, rand_word(), 0, 0);
        add_entry(OP_SW, 'h044, rand_word(), 0, 1);
        add_entry(OP_LW, 'h040, rand_word(), 0, 1);
        add_entry(OP_LH, 'h046, rand_word(), 0, 1);
        add_entry(OP_LBU, 'h045, rand_word(), 0, 1);
        add_entry(OP_SB, 'h041, rand_word(), 0, 1);
        add_entry(OP_LW, 'h040, rand_word(), 0, 1);
        add_entry(OP_LHU, 'h042, rand_word(), 0, 1);
        // memory stalled ahead of a command
        add_entry(OP_SW, 'h048, rand_word(), 3, 0);
        add_entry(OP_LW, 'h048, rand_word(), 5, 0);
        add_entry(OP_LW, 'h044, rand_word(), 0, 1);
        add_entry(OP_LHU, 'h04a, rand_word(), 2, 0);
        add_entry(OP_SW, 'h04c, rand_word(), 4, 0);
        add_entry(OP_LB, 'h04f, rand_word(), 0, 1);
        // random mix over the words written above
        for (int k = 0; k < 12; k++) begin
            w   = rand_word();
            op  = op_t'(w[2:0]);
            stl = (k % 3 == 0) ? 2 : 0;
            add_entry(op, 'h040 + w[7:4], rand_word(), stl, (stl == 0) && k[0]);
        end
    endtask

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic check_rdt(input logic [DAT_W-1:0] got, input logic [DAT_W-1:0] exp,
                             input int idx);
        if (got !== exp) begin
            fail_stop($sformatf("Error: %0d ns: entry %0d rsp_rdt %h, expected %h",
                                $time, idx, got, exp));
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input int idx);
        if (got !== exp) begin
            fail_stop($sformatf("Error: %0d ns: entry %0d rsp_err %b, expected %b",
                                $time, idx, got, exp));
        end
    endtask

    task automatic check_rdy(input logic got, input logic exp, input int idx);
        if (got !== exp) begin
            fail_stop($sformatf("Error: %0d ns: entry %0d cmd_rdy %b, expected %b",
                                $time, idx, got, exp));
        end
    endtask

    task automatic check_lat(input int got, input int exp, input int idx);
        if (got != exp) begin
            fail_stop($sformatf("Error: %0d ns: entry %0d response on edge %0d, expected %0d",
                                $time, idx, got, exp));
        end
    endtask

    //////////////////////////////
    // driver and checker
    //////////////////////////////

    task automatic drive_cmds();
        int k;
        bit acc;
        for (int i = 0; i < tbl_n; i++) begin
            if (!tbl_b2b[i]) begin
                // the slice must be empty before the memory stalls
                cmd_vld = 1'b0;
                k = 0;
                while (n_rsp != i) begin
                    @(posedge sub);
                    #DRV_DLY;
                    k++;
                    if (k > RSP_TMO) fail_stop("timeout while waiting for responses to drain");
                end
                if (tbl_stall[i] != 0) begin
                    mem_stall = 1'b1;
                    repeat (tbl_stall[i]) begin
                        @(posedge sub);
                        #DRV_DLY;
                    end
                    mem_stall = 1'b0;
                end
            end
            cmd_vld = 1'b1;
            cmd_op  = tbl_op[i];
            cmd_adr = tbl_adr[i];
            cmd_wdt = tbl_wdt[i];
            acc = 0;
            k   = 0;
            // accepted on the next edge if ready is high mid-cycle
            while (!acc) begin
                @(negedge sub);
                // a back to back entry goes in on the very next edge
                if (tbl_b2b[i] && k == 0) check_rdy(cmd_rdy, 1'b1, i);
                if (cmd_rdy === 1'b1) begin
                    acc = 1;
                    acc_q.push_back(cyc + 1);
                end else begin
                    k++;
                    if (k > RDY_TMO) fail_stop("timeout while waiting for cmd_rdy");
                end
            end
            @(posedge sub);
            #DRV_DLY;
        end
        cmd_vld = 1'b0;
    endtask

    task automatic check_rsps();
        int k;
        int acc;
        bit got;
        for (int i = 0; i < tbl_n; i++) begin
            got = 0;
            k   = 0;
            while (!got) begin
                @(negedge sub);
                if (rsp_vld === 1'b1) begin
                    got = 1;
                end else begin
                    k++;
                    if (k > RSP_TMO) begin
                        fail_stop($sformatf("timeout while waiting for rsp_vld of entry %0d",
                                            i));
                    end
                end
            end
            if (acc_q.size() == 0) begin
                fail_stop($sformatf("Error: %0d ns: response %0d before any accepted command",
                                    $time, i));
            end
            acc = acc_q.pop_front();
            // pulse is captured on the coming edge
            check_lat(cyc + 1, acc + BUS_DLY, i);
            check_rdt(rsp_rdt, tbl_rdt[i], i);
            check_err(rsp_err, tbl_err[i], i);
            n_rsp++;
        end
    endtask

    initial begin
        int k;
        cmd_vld   = 1'b0;
        cmd_op    = OP_LW;
        cmd_adr   = '0;
        cmd_wdt   = '0;
        mem_stall = 1'b0;
        build_table();
        k = 0;
        while (rst_n !== 1'b1) begin
            @(posedge sub);
            k++;
            if (k > RST_TMO) fail_stop("timeout while waiting for reset release");
        end
        @(posedge sub);
        #DRV_DLY;
        fork
            drive_cmds();
            check_rsps();
        join
        // no stray pulse once the table is done
        repeat (4) begin
            @(negedge sub);
            if (rsp_vld !== 1'b0) begin
                fail_stop($sformatf("Error: %0d ns: rsp_vld without a command", $time));
            end
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule : tb_tcb_lsu_top

`default_nettype wire

//--- filelist.f
tcb_lsu_pkg.sv
tcb_lsu_manager.sv
tcb_register_request.sv
tcb_memory_sub.sv
tcb_lsu_top.sv
tb_clock_gen.sv
tb_tcb_lsu_top.sv
